// File: project.f
hw/ifu_pkg.sv
hw/ifu_fetch_ctl.sv
hw/ifu_iq.sv
hw/ifu_pc_dp.sv
hw/ifu_top.sv
dv/tb_ifu.sv

// File: Makefile
# Verilator flow for the fetch front end

VERILATOR ?= verilator
TOP       := tb_ifu
FILELIST  := project.f
OBJDIR    := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJDIR)
LINTFLAGS := --lint-only --timing --top-module $(TOP)
PASS_MSG  := Simulation PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

# the run passes only if the pass message shows up on a line of its own
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: dv/ifu_stim.txt
# columns: cycles after previous event, event, operand address, expected next pc (hex)
# events: none branch except ertn both stall; expected 00000000 means keep going sequentially
0 none 00000000 1c000000
12 stall 00000000 00000000
5 stall 00000000 00000000
9 branch 1c000100 1c000100
7 none 00000000 00000000
6 branch 1c000204 1c000204
3 stall 00000000 00000000
2 stall 00000000 00000000
10 except 1c008000 1c008000
4 branch 1c000300 1c000300
8 ertn 1c000040 1c000040
5 both 1c008040 1c008040
3 branch 1c00010c 1c00010c
2 branch 1c000400 1c000400
11 stall 00000000 00000000
4 ertn 1c000444 1c000444
6 branch 1c000500 1c000500
5 except 1c008100 1c008100
2 ertn 1c00050c 1c00050c
9 stall 00000000 00000000
3 stall 00000000 00000000
7 branch 1c000600 1c000600
4 both 1c008180 1c008180
6 ertn 1c000604 1c000604
3 branch 1c000700 1c000700
8 stall 00000000 00000000
5 except 1c008200 1c008200
4 branch 1c000804 1c000804
10 stall 00000000 00000000
6 none 00000000 00000000

// File: dv/tb_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ifu;

   localparam int MAX_LINES = 64;

   logic               clk;
   logic               reset;
   logic               stall;
   ifu_pkg::redirect_t redir;
   ifu_pkg::icu_rsp_t  icu_rsp;
   ifu_pkg::icu_req_t  icu_req;
   ifu_pkg::dec_out_t  dec;
   logic               valid_e;
   logic [31:0]        pc_e;
   logic [31:0]        pc_w;
   logic               redir_any;

   // stimulus table
   int                 n_lines;
   int                 off_tab [MAX_LINES];
   string              ev_tab [MAX_LINES];
   logic [31:0]        op_tab [MAX_LINES];
   logic [31:0]        exp_tab [MAX_LINES];
   logic [31:0]        redir_exp;

   // icache model
   logic               rsp_ack;
   logic [63:0]        rsp_data;
   logic               rsp_dv;
   logic               pend;
   logic [31:0]        pend_addr;
   int                 dly;

   // reference model and checker state
   int                 errors;
   int                 checks;
   int                 issued;
   logic [31:0]        exp_pc;
   logic [31:0]        last_pc;
   logic               e_due;
   logic               hold_chk;
   logic               was_held;
   logic [31:0]        hold_pc_d;
   logic [31:0]        hold_pc_e;
   logic               hold_vld_e;
   logic               seen_edge;
   logic               seen_req;
   logic               post_rst;
   int                 hist_n;
   logic [31:0]        pc_e_hist1;
   logic [31:0]        pc_e_hist2;

   ifu_top DUT (
      .clk     (clk),
      .reset   (reset),
      .icu_rsp (icu_rsp),
      .redir   (redir),
      .stall   (stall),
      .icu_req (icu_req),
      .dec     (dec),
      .valid_e (valid_e),
      .pc_e    (pc_e),
      .pc_w    (pc_w)
   );

   assign redir_any = redir.br_taken | redir.except | redir.ertn;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED @%0t: %s, got %h expected %h", $time, msg, got, exp);
      end
   endtask

   // both words of the aligned line as addr ^ magic
   function automatic logic [63:0] line_for(input logic [31:0] addr);
      logic [31:0] base;
      base     = {addr[31:3], 3'b000};
      line_for = {(base | 32'h4) ^ ifu_pkg::INST_MAGIC, base ^ ifu_pkg::INST_MAGIC};
   endfunction

   // ==========================================================================
   // icache model
   // ==========================================================================

   // ack in the cycle of req
   assign rsp_ack = (icu_req.req === 1'b1);
   assign icu_rsp = {rsp_ack, rsp_data, rsp_dv};

   always @(posedge clk) begin
      if (reset) begin
         rsp_dv <= 1'b0;
         pend   <= 1'b0;
      end else begin
         rsp_dv <= 1'b0;
         if (pend) begin
            pend <= 1'b0;
            // cancelled line is dropped
            if (!icu_req.cancel) begin
               rsp_dv   <= 1'b1;
               rsp_data <= line_for(pend_addr);
            end
         end
         if (rsp_ack) begin
            // one or two cycles to data_valid
            dly = int'($urandom_range(2, 1));
            if (dly == 1) begin
               rsp_dv   <= 1'b1;
               rsp_data <= line_for(icu_req.addr);
            end else begin
               pend      <= 1'b1;
               pend_addr <= icu_req.addr;
            end
         end
      end
   end

   // ==========================================================================
   // checker on pre-edge values
   // ==========================================================================

   always @(posedge clk) begin
      if (reset) begin
         if (seen_edge) begin
            check_value(32'(icu_req.req), 32'd0, "req during reset");
            check_value(32'(valid_e), 32'd0, "valid_e during reset");
         end
         seen_edge = 1'b1;
         post_rst  = 1'b1;
         hist_n    = 0;
         hold_chk  = 1'b0;
         e_due     = 1'b0;
      end else begin
         if (post_rst) begin
            check_value(32'(icu_req.req), 32'd0, "req in first cycle after reset");
            check_value(32'(icu_req.cancel), 32'd0, "cancel in first cycle after reset");
            check_value(32'(valid_e), 32'd0, "valid_e in first cycle after reset");
            check_value(32'(dec.valid), 32'd0, "dec.valid in first cycle after reset");
            post_rst = 1'b0;
         end
         // first request goes to the reset vector
         if (icu_req.req && !seen_req) begin
            check_value(icu_req.addr, ifu_pkg::PC_RESET, "first request address");
            seen_req = 1'b1;
         end
         // cancel exactly when a redirect hits a line in flight
         check_value(32'(icu_req.cancel), 32'(pend & redir_any), "cancel pulse");
         // stage registers frozen over a stall
         was_held = hold_chk;
         if (hold_chk) begin
            check_value(dec.pc, hold_pc_d, "dec.pc held over stall");
            check_value(pc_e, hold_pc_e, "pc_e held over stall");
            check_value(32'(valid_e), 32'(hold_vld_e), "valid_e held over stall");
            hold_chk = 1'b0;
         end
         if (stall) begin
            check_value(32'(icu_req.req), 32'd0, "request issued during stall");
            hold_pc_d  = dec.pc;
            hold_pc_e  = pc_e;
            hold_vld_e = valid_e;
            hold_chk   = 1'b1;
         end
         // execute holds the last issue and nothing else
         if (e_due) begin
            check_value(32'(valid_e), 32'd1, "valid_e after issue");
            check_value(pc_e, last_pc, "pc_e after issue");
         end else if (!was_held) begin
            check_value(32'(valid_e), 32'd0, "valid_e without an issue");
         end
         e_due = 1'b0;
         // issue stream against the reference
         if (dec.valid) begin
            check_value(dec.pc, exp_pc, "decode pc");
            check_value(dec.inst, exp_pc ^ ifu_pkg::INST_MAGIC, "decode instruction");
            last_pc = exp_pc;
            exp_pc  = exp_pc + 32'd4;
            e_due   = 1'b1;
            issued++;
         end
         // redirect restarts the stream at the new target
         if (redir_any) begin
            check_value(icu_req.addr, redir_exp, "request address on redirect");
            exp_pc = redir_exp;
         end
         if (hist_n >= 2) begin
            check_value(pc_w, pc_e_hist2, "pc_w against pc_e two cycles back");
         end
         pc_e_hist2 = pc_e_hist1;
         pc_e_hist1 = pc_e;
         if (hist_n < 2) begin
            hist_n++;
         end
      end
   end

   // ==========================================================================
   // stimulus
   // ==========================================================================

   task automatic load_stim();
      int          fd;
      int          off;
      string       text;
      string       ev;
      logic [31:0] op;
      logic [31:0] ex;
      n_lines = 0;
      fd      = $fopen("dv/ifu_stim.txt", "r");
      if (fd != 0) begin
         while (!$feof(fd) && n_lines < MAX_LINES) begin
            void'($fgets(text, fd));
            // comment lines fail the parse
            if ($sscanf(text, "%d %s %h %h", off, ev, op, ex) == 4) begin
               off_tab[n_lines] = off;
               ev_tab[n_lines]  = ev;
               op_tab[n_lines]  = op;
               exp_tab[n_lines] = ex;
               n_lines++;
            end
         end
         $fclose(fd);
      end
   endtask

   // one-cycle redirect or stall
   task automatic apply_event(input string ev, input logic [31:0] op,
                              input logic [31:0] ex);
      ifu_pkg::redirect_t r;
      r = '0;
      if (ev == "branch") begin
         r.br_taken  = 1'b1;
         r.br_target = op;
      end else if (ev == "except") begin
         r.except = 1'b1;
         r.eentry = op;
      end else if (ev == "ertn") begin
         r.ertn = 1'b1;
         r.era  = op;
      end else if (ev == "both") begin
         // era points elsewhere so the exception has to win
         r.except = 1'b1;
         r.eentry = op;
         r.ertn   = 1'b1;
         r.era    = op ^ 32'h0000_0f00;
      end else if (ev != "none" && ev != "stall") begin
         $display("unknown event %s in the stimulus file", ev);
         errors++;
      end
      redir     <= r;
      redir_exp <= ex;
      if (ev == "stall") begin
         stall <= 1'b1;
      end
      @(posedge clk);
      redir <= '0;
      stall <= 1'b0;
   endtask

   initial begin
      void'($urandom(55));
      reset     = 1'b1;
      stall     = 1'b0;
      redir     = '0;
      redir_exp = '0;
      rsp_data  = '0;
      rsp_dv    = 1'b0;
      pend      = 1'b0;
      pend_addr = '0;
      errors    = 0;
      checks    = 0;
      issued    = 0;
      e_due     = 1'b0;
      hold_chk  = 1'b0;
      seen_edge = 1'b0;
      seen_req  = 1'b0;
      post_rst  = 1'b0;
      hist_n    = 0;
      load_stim();
      if (n_lines == 0) begin
         $display("could not read any stimulus from dv/ifu_stim.txt");
         $display("Simulation FAILED");
         $finish;
      end else begin
         // reference stream starts at the first line's expected pc
         exp_pc = exp_tab[0];
         repeat (2) @(posedge clk);
         reset <= 1'b0;
         for (int i = 0; i < n_lines; i++) begin
            repeat (off_tab[i]) @(posedge clk);
            apply_event(ev_tab[i], op_tab[i], exp_tab[i]);
         end
         repeat (30) @(posedge clk);
         check_value(32'(issued >= 20), 32'd1, "too few instructions issued");
         $display("checks %0d, issued %0d, errors %0d", checks, issued, errors);
         if (errors == 0) begin
            $display("Simulation PASSED");
         end else begin
            $display("Simulation FAILED");
         end
         $finish;
      end
   end

   // watchdog allows 40 cycles per stimulus line
   initial begin
      wait (n_lines > 0);
      repeat (n_lines * 40) @(posedge clk);
      $display("watchdog timeout, the run did not end within %0d cycles", n_lines * 40);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: hw/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top (
   input  logic                      clk,
   input  logic                      reset,
   input  ifu_pkg::icu_rsp_t         icu_rsp,
   input  ifu_pkg::redirect_t        redir,
   input  logic                      stall,
   output ifu_pkg::icu_req_t         icu_req,
   output ifu_pkg::dec_out_t         dec,
   output logic                      valid_e,
   output logic [ifu_pkg::GRLEN-1:0] pc_e,
   output logic [ifu_pkg::GRLEN-1:0] pc_w
);

   // control to datapath
   logic                      req;
   logic                      cancel;
   ifu_pkg::pc_sel_e          pc_sel;

   // datapath pcs
   logic [ifu_pkg::GRLEN-1:0] pc_bf;
   logic [ifu_pkg::GRLEN-1:0] pc_f;

   // queue outputs
   logic [ifu_pkg::GRLEN-1:0] inst_f;
   logic                      inst_valid_f;
   logic                      iq_not_empty;
   logic                      fetch_ahead;

   logic                      redir_any;

   assign redir_any = redir.br_taken | redir.except | redir.ertn;

   // icache request, address straight from the next-pc mux
   assign icu_req.req    = req;
   assign icu_req.addr   = pc_bf;
   assign icu_req.cancel = cancel;

   // =========================================================================
   // blocks
   // =========================================================================

   ifu_fetch_ctl u_fetch_ctl (
      .clk          (clk),
      .reset        (reset),
      .rsp          (icu_rsp),
      .redir        (redir),
      .stall        (stall),
      .iq_not_empty (iq_not_empty),
      .fetch_ahead  (fetch_ahead),
      .addr_hi      (pc_bf[2]),
      .req          (req),
      .cancel       (cancel),
      .pc_sel       (pc_sel)
   );

   ifu_iq u_iq (
      .clk          (clk),
      .reset        (reset),
      .rsp          (icu_rsp),
      .pc_f2        (pc_f[2]),
      .redir_any    (redir_any),
      .stall        (stall),
      .inst_f       (inst_f),
      .inst_valid_f (inst_valid_f),
      .iq_not_empty (iq_not_empty),
      .fetch_ahead  (fetch_ahead)
   );

   ifu_pc_dp u_pc_dp (
      .clk          (clk),
      .reset        (reset),
      .pc_sel       (pc_sel),
      .redir        (redir),
      .stall        (stall),
      .inst_f       (inst_f),
      .inst_valid_f (inst_valid_f),
      .pc_bf        (pc_bf),
      .pc_f         (pc_f),
      .dec          (dec),
      .valid_e      (valid_e),
      .pc_e         (pc_e),
      .pc_w         (pc_w)
   );

endmodule

`default_nettype wire

// File: hw/ifu_pc_dp.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_pc_dp (
   input  logic                      clk,
   input  logic                      reset,
   input  ifu_pkg::pc_sel_e          pc_sel,
   input  ifu_pkg::redirect_t        redir,
   input  logic                      stall,
   input  logic [ifu_pkg::GRLEN-1:0] inst_f,
   input  logic                      inst_valid_f,
   output logic [ifu_pkg::GRLEN-1:0] pc_bf,
   output logic [ifu_pkg::GRLEN-1:0] pc_f,
   output ifu_pkg::dec_out_t         dec,
   output logic                      valid_e,
   output logic [ifu_pkg::GRLEN-1:0] pc_e,
   output logic [ifu_pkg::GRLEN-1:0] pc_w
);

   logic [ifu_pkg::GRLEN-1:0] pcinc_f;
   logic [ifu_pkg::GRLEN-1:0] pc_d;
   logic [ifu_pkg::GRLEN-1:0] pc_m;
   logic [ifu_pkg::GRLEN-1:0] inst_d;

   logic kill_f;
   logic kill_d;
   logic vld_kill_f;
   logic vld_kill_d;
   logic valid_d;
   logic en_f2d;

   // =========================================================================
   // fetch pc
   // =========================================================================

   // word aligned, so only bits 31:2 count
   assign pcinc_f = {pc_f[ifu_pkg::GRLEN-1:2] + 30'd1, pc_f[1:0]};

   always_comb begin
      case (pc_sel)
         ifu_pkg::PCS_INIT:   pc_bf = ifu_pkg::PC_RESET;
         ifu_pkg::PCS_HOLD:   pc_bf = pc_f;
         ifu_pkg::PCS_INC:    pc_bf = pcinc_f;
         ifu_pkg::PCS_BRANCH: pc_bf = redir.br_target;
         ifu_pkg::PCS_EXCEPT: pc_bf = redir.eentry;
         ifu_pkg::PCS_ERTN:   pc_bf = redir.era;
         default:             pc_bf = pc_f;
      endcase
   end

   // bf to f every cycle, hold comes through the mux
   always_ff @(posedge clk) begin
      pc_f <= pc_bf;
   end

   // =========================================================================
   // kill and valid chain
   // =========================================================================

   // any redirect kills the word at fetch
   assign kill_f     = redir.br_taken | redir.except | redir.ertn;
   assign vld_kill_f = inst_valid_f & ~kill_f;

   // ertn leaves decode alone
   // stall keeps decode from issuing
   assign kill_d     = redir.br_taken | redir.except | stall;
   assign vld_kill_d = valid_d & ~kill_d;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_d <= 1'b0;
         valid_e <= 1'b0;
      end else if (~stall) begin
         valid_d <= vld_kill_f;
         valid_e <= vld_kill_d;
      end
   end

   // =========================================================================
   // stage registers
   // =========================================================================

   assign en_f2d = vld_kill_f & ~stall;

   always_ff @(posedge clk) begin
      if (en_f2d) begin
         pc_d   <= pc_f;
         inst_d <= inst_f;
      end
   end

   // vld_kill_d already folds in stall
   always_ff @(posedge clk) begin
      if (vld_kill_d) begin
         pc_e <= pc_d;
      end
   end

   // memory and writeback just trail execute
   always_ff @(posedge clk) begin
      pc_m <= pc_e;
      pc_w <= pc_m;
   end

   // to decode
   assign dec.pc    = pc_d;
   assign dec.inst  = inst_d;
   assign dec.valid = vld_kill_d;

endmodule

`default_nettype wire

// File: hw/ifu_iq.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_iq (
   input  logic                       clk,
   input  logic                       reset,
   input  ifu_pkg::icu_rsp_t          rsp,
   input  logic                       pc_f2,
   input  logic                       redir_any,
   input  logic                       stall,
   output logic [ifu_pkg::GRLEN-1:0]  inst_f,
   output logic                       inst_valid_f,
   output logic                       iq_not_empty,
   output logic                       fetch_ahead
);

   // one 64-bit line and its flag
   logic [ifu_pkg::LINE_W-1:0] line_q;
   logic                       line_vld_q;

   // halves of the held line
   logic [ifu_pkg::GRLEN-1:0]  word_lo;
   logic [ifu_pkg::GRLEN-1:0]  word_hi;

   logic                       load;
   logic                       drain;

   // =========================================================================
   // fill and drain
   // =========================================================================

   // a line racing a redirect belongs to the old path
   assign load = rsp.data_valid & ~redir_any;

   // high word issues, line is used up
   assign drain = line_vld_q & pc_f2 & ~stall;

   always_ff @(posedge clk) begin
      if (reset) begin
         line_vld_q <= 1'b0;
      end else if (redir_any) begin
         // flush on any redirect
         line_vld_q <= 1'b0;
      end else if (load) begin
         line_vld_q <= 1'b1;
      end else if (drain) begin
         line_vld_q <= 1'b0;
      end
   end

   // line payload
   always_ff @(posedge clk) begin
      if (load) begin
         line_q <= rsp.data;
      end
   end

   // =========================================================================
   // word select
   // =========================================================================

   assign word_lo = line_q[ifu_pkg::GRLEN-1:0];
   assign word_hi = line_q[ifu_pkg::LINE_W-1:ifu_pkg::GRLEN];

   // pc_f[2] picks the half
   assign inst_f = pc_f2 ? word_hi : word_lo;

   // line always covers pc_f while held
   assign inst_valid_f = line_vld_q;

   // =========================================================================
   // status back to fetch control
   // =========================================================================

   assign iq_not_empty = line_vld_q;

   // low word still pending, the next line may go out early
   assign fetch_ahead = line_vld_q & ~pc_f2;

endmodule

`default_nettype wire

// File: hw/ifu_fetch_ctl.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_ctl (
   input  logic               clk,
   input  logic               reset,
   input  ifu_pkg::icu_rsp_t  rsp,
   input  ifu_pkg::redirect_t redir,
   input  logic               stall,
   input  logic               iq_not_empty,
   input  logic               fetch_ahead,
   input  logic               addr_hi,
   output logic               req,
   output logic               cancel,
   output ifu_pkg::pc_sel_e   pc_sel
);

   ifu_pkg::fetch_state_e state_q;
   ifu_pkg::fetch_state_e state_d;
   logic                  boot_q;
   logic                  redir_any;
   logic                  idle;
   logic                  busy;

   assign redir_any = redir.br_taken | redir.except | redir.ertn;
   assign idle      = (state_q == ifu_pkg::FS_IDLE);
   assign busy      = (state_q == ifu_pkg::FS_BUSY);

   // =========================================================================
   // icache request side
   // =========================================================================

   // drop the line in flight on redirect
   // a line landing this same cycle just finishes, the queue ignores it
   assign cancel = busy & redir_any & ~rsp.data_valid;

   // empty queue, or fetch ahead on a line boundary only
   // boot_q keeps the first cycle after reset quiet
   assign req = ~boot_q & idle & ~stall &
                (~iq_not_empty | (fetch_ahead & ~addr_hi));

   // =========================================================================
   // next pc source, highest priority first
   // =========================================================================

   always_comb begin
      if (reset) begin
         pc_sel = ifu_pkg::PCS_INIT;
      end else if (redir.except) begin
         pc_sel = ifu_pkg::PCS_EXCEPT;
      end else if (redir.ertn) begin
         pc_sel = ifu_pkg::PCS_ERTN;
      end else if (redir.br_taken) begin
         pc_sel = ifu_pkg::PCS_BRANCH;
      end else if (stall | ~iq_not_empty) begin
         // nothing issues this cycle
         pc_sel = ifu_pkg::PCS_HOLD;
      end else begin
         pc_sel = ifu_pkg::PCS_INC;
      end
   end

   // =========================================================================
   // fetch fsm
   // =========================================================================

   always_comb begin
      state_d = state_q;
      case (state_q)
         ifu_pkg::FS_IDLE: begin
            if (req & rsp.ack) begin
               state_d = ifu_pkg::FS_BUSY;
            end
         end
         ifu_pkg::FS_BUSY: begin
            if (cancel) begin
               state_d = ifu_pkg::FS_CANCEL;
            end else if (rsp.data_valid) begin
               state_d = ifu_pkg::FS_IDLE;
            end
         end
         // one dead cycle, then refetch from idle
         ifu_pkg::FS_CANCEL: state_d = ifu_pkg::FS_IDLE;
         default:            state_d = ifu_pkg::FS_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= ifu_pkg::FS_IDLE;
         boot_q  <= 1'b1;
      end else begin
         state_q <= state_d;
         boot_q  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: hw/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

   // =========================================================================
   // widths and constants
   // =========================================================================

   // register and pc width
   localparam int GRLEN = 32;
   // one cache line, two instruction words
   localparam int LINE_W = 64;

   // reset vector
   localparam logic [GRLEN-1:0] PC_RESET = 32'h1c00_0000;
   // cache model returns addr ^ magic for every word
   localparam logic [GRLEN-1:0] INST_MAGIC = 32'h5a3c_96e1;

   // =========================================================================
   // encodings
   // =========================================================================

   // next fetch pc source
   typedef enum logic [2:0] {
      PCS_INIT   = 3'd0,
      PCS_HOLD   = 3'd1,
      PCS_INC    = 3'd2,
      PCS_BRANCH = 3'd3,
      PCS_EXCEPT = 3'd4,
      PCS_ERTN   = 3'd5
   } pc_sel_e;

   // fetch fsm
   typedef enum logic [1:0] {
      FS_IDLE   = 2'd0,
      FS_BUSY   = 2'd1,
      FS_CANCEL = 2'd2
   } fetch_state_e;

   // =========================================================================
   // port groups
   // =========================================================================

   // fetch to icache
   typedef struct packed {
      logic             req;
      logic [GRLEN-1:0] addr;
      logic             cancel;
   } icu_req_t;

   // icache to fetch
   typedef struct packed {
      logic              ack;
      logic [LINE_W-1:0] data;
      logic              data_valid;
   } icu_rsp_t;

   // execute to fetch, one-cycle levels
   typedef struct packed {
      logic             br_taken;
      logic [GRLEN-1:0] br_target;
      logic             except;
      logic [GRLEN-1:0] eentry;
      logic             ertn;
      logic [GRLEN-1:0] era;
   } redirect_t;

   // fetch to decode
   typedef struct packed {
      logic [GRLEN-1:0] pc;
      logic [GRLEN-1:0] inst;
      logic             valid;
   } dec_out_t;

endpackage

`default_nettype wire
